// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module tbConfigTop -Mdir obj_dir
	./obj_dir/VtbConfigTop | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== apbConfigPort.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fabric_cfg.svh"

module apbConfigPort (
  input  wire logic              CLK,
  input  wire logic              resetn,
  input  wire logic              psel,
  input  wire logic              penable,
  input  wire logic              pwrite,
  input  wire cfgBusPkg::apbAddrT paddr,
  input  wire logic [31:0]       pwdata,
  output logic      [31:0]       prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic      [31:0]       wordData,
  output logic                   wordStrobe,
  output logic                   fsmReset,
  input  wire logic              synced,
  cfgReadIf.port                 rd
);

  import cfgBusPkg::*;
  import frameTypesPkg::*;

  logic     accessPhase;          // second APB cycle
  logic     writeAccess;
  logic     mapped;               // offset hits a register
  logic     readOnly;             // STATUS or RDDATA
  logic     comActive;
  frameIdxT rdFrame;
  rowIdxT   rdRow;

  assign accessPhase = psel & penable;
  assign writeAccess = accessPhase & pwrite;
  assign pready      = 1'b1;      // no wait states
  assign pslverr     = accessPhase & (~mapped | (pwrite & readOnly));
  assign fsmReset    = comActive;
  assign rd.readFrame = rdFrame;
  assign rd.readRow   = rdRow;

  always_comb begin
    mapped   = 1'b1;
    readOnly = 1'b0;
    case (paddr)
      CTRL, DATA, RDSEL: mapped = 1'b1;
      STATUS, RDDATA:    readOnly = 1'b1;
      default:           mapped = 1'b0;   // hole in the map
    endcase
  end

  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      comActive  <= 1'b0;
      rdFrame    <= '0;
      rdRow      <= '0;
      wordStrobe <= 1'b0;
    end else begin
      wordStrobe <= writeAccess && (paddr == DATA);   // one cycle after access
      if (writeAccess && (paddr == CTRL)) begin
        comActive <= pwdata[ctrlComActiveBit];
      end
      if (writeAccess && (paddr == RDSEL)) begin
        rdFrame <= pwdata[rdselFrameLsb +: $bits(frameIdxT)];
        rdRow   <= pwdata[rdselRowLsb +: $bits(rowIdxT)];
      end
    end
  end

  // word is valid together with wordStrobe
  always_ff @(posedge CLK) begin
    if (writeAccess && (paddr == DATA)) begin
      wordData <= pwdata;
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      CTRL: prdata[ctrlComActiveBit] = comActive;
      STATUS: begin
        prdata[statusSyncedBit]                         = synced;
        prdata[statusCountLsb +: $bits(frameCountT)]    = rd.frameCount;
      end
      RDSEL: begin
        prdata[rdselFrameLsb +: $bits(frameIdxT)] = rdFrame;
        prdata[rdselRowLsb +: $bits(rowIdxT)]     = rdRow;
      end
      RDDATA:  prdata = rd.readData;
      default: prdata = '0;       // DATA and holes read zero
    endcase
  end

endmodule

`default_nettype wire

// ==== cfgBusPkg.sv ====
`default_nettype none

package cfgBusPkg;

  typedef logic [7:0] apbAddrT;   // byte address on the APB port

  // register map, byte offsets
  typedef enum logic [7:0] {
    CTRL   = 8'h00,               // r/w, comActive
    DATA   = 8'h04,               // write only, bitstream word
    STATUS = 8'h08,               // read only
    RDSEL  = 8'h0C,               // r/w, readback frame/row
    RDDATA = 8'h10                // read only, readback word
  } regOffsetE;

  // field positions inside the registers
  localparam int ctrlComActiveBit = 0;
  localparam int statusSyncedBit  = 0;
  localparam int statusCountLsb   = 8;   // frameCount in 15:8
  localparam int rdselFrameLsb    = 0;   // frame in 2:0
  localparam int rdselRowLsb      = 8;   // row in 11:8

endpackage

`default_nettype wire

// ==== cfgReadIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cfgReadIf;

  import frameTypesPkg::*;

  frameIdxT    readFrame;         // frame to read back
  rowIdxT      readRow;           // row inside that frame
  logic [31:0] readData;          // stored word, combinational
  frameCountT  frameCount;        // frames committed so far

  // APB side selects and reads
  modport port (
    output readFrame,
    output readRow,
    input  readData,
    input  frameCount
  );

  // loader side serves the word
  modport loader (
    input  readFrame,
    input  readRow,
    output readData,
    output frameCount
  );

endinterface

`default_nettype wire

// ==== configFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fabric_cfg.svh"

module configFsm (
  input  wire logic                    CLK,
  input  wire logic                    resetn,
  input  wire logic [31:0]             wordData,
  input  wire logic                    wordStrobe,
  input  wire logic                    fsmReset,
  output logic      [`FRAME_BITS-1:0]  frameAddr,
  output frameTypesPkg::rowSelT        rowSelect,
  output logic                         longStrobe,
  output logic                         synced
);

  import frameTypesPkg::*;

  localparam rowSelT rowsPerFrame = rowSelT'(`NUM_ROWS);
  localparam rowSelT lastRow      = rowSelT'(1);

  cfgStateE state;
  rowSelT   rowCount;             // counts NUM_ROWS down to 1
  logic     prevReset;            // for comActive edge
  logic     frameStrobe;          // one cycle after last row
  logic     prevFrameStrobe;
  logic     resetEdge;

  assign resetEdge = fsmReset & ~prevReset;
  assign synced    = (state != UNSYNCED);

  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      state       <= UNSYNCED;
      rowCount    <= '0;
      prevReset   <= 1'b0;
      frameStrobe <= 1'b0;
      frameAddr   <= '0;
    end else begin
      prevReset   <= fsmReset;
      frameStrobe <= 1'b0;        // pulse default
      if (resetEdge) begin        // comActive rising, drop everything
        state    <= UNSYNCED;
        rowCount <= '0;
      end else begin
        case (state)
          UNSYNCED: begin
            // the host may send any preamble before the sync word
            if (wordStrobe && (wordData == `SYNC_WORD)) begin
              state <= SYNCED;
            end
          end
          SYNCED: begin
            if (wordStrobe) begin
              if (wordData[`DESYNC_BIT]) begin
                state <= UNSYNCED;        // desync header
              end else begin
                frameAddr <= wordData;    // frame header
                rowCount  <= rowsPerFrame;
                state     <= LOADING;
              end
            end
          end
          LOADING: begin
            if (wordStrobe) begin
              rowCount <= rowCount - 1'b1;
              if (rowCount == lastRow) begin
                frameStrobe <= 1'b1;      // frame complete
                state       <= SYNCED;    // next header or desync
              end
            end
          end
          default: state <= UNSYNCED;
        endcase
      end
    end
  end

  // row only valid while a data word is on the bus
  always_comb begin
    if (wordStrobe && (state == LOADING)) begin
      rowSelect = rowCount;
    end else begin
      rowSelect = '1;             // invalid row
    end
  end

  // stretch to two cycles, one cycle late
  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      prevFrameStrobe <= 1'b0;
      longStrobe      <= 1'b0;
    end else begin
      prevFrameStrobe <= frameStrobe;
      longStrobe      <= frameStrobe | prevFrameStrobe;
    end
  end

endmodule

`default_nettype wire

// ==== configTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fabric_cfg.svh"

module configTop (
  input  wire logic               CLK,
  input  wire logic               resetn,
  input  wire logic               psel,
  input  wire logic               penable,
  input  wire logic               pwrite,
  input  wire cfgBusPkg::apbAddrT paddr,
  input  wire logic [31:0]        pwdata,
  output logic      [31:0]        prdata,
  output logic                    pready,
  output logic                    pslverr
);

  import frameTypesPkg::*;

  logic [31:0]            wordData;     // shared by fsm and loader
  logic                   wordStrobe;
  logic                   fsmReset;     // comActive level
  logic                   synced;
  logic [`FRAME_BITS-1:0] frameAddr;
  rowSelT                 rowSelect;
  logic                   longStrobe;

  cfgReadIf readBus ();           // readback and status

  apbConfigPort iApbPort (
    .CLK        (CLK),
    .resetn     (resetn),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .wordData   (wordData),
    .wordStrobe (wordStrobe),
    .fsmReset   (fsmReset),
    .synced     (synced),
    .rd         (readBus.port)
  );

  configFsm iConfigFsm (
    .CLK        (CLK),
    .resetn     (resetn),
    .wordData   (wordData),
    .wordStrobe (wordStrobe),
    .fsmReset   (fsmReset),
    .frameAddr  (frameAddr),
    .rowSelect  (rowSelect),
    .longStrobe (longStrobe),
    .synced     (synced)
  );

  frameLoader iFrameLoader (
    .CLK        (CLK),
    .resetn     (resetn),
    .wordData   (wordData),
    .rowSelect  (rowSelect),
    .frameAddr  (frameAddr),
    .longStrobe (longStrobe),
    .rd         (readBus.loader)
  );

endmodule

`default_nettype wire

// ==== fabric_cfg.svh ====
`ifndef FABRIC_CFG_SVH
`define FABRIC_CFG_SVH

// fabric geometry
`define NUM_ROWS      16          // rows per frame
`define ROW_SEL_WIDTH 5           // row select, all ones is invalid
`define FRAME_BITS    32          // frame address register width
`define NUM_FRAMES    8           // frames held in config memory

// bitstream constants
`define DESYNC_BIT    20          // header bit, drops back to unsynced
`define SYNC_WORD     32'hFAB0_FAB1

`endif

// ==== filelist.f ====
+incdir+.
cfgBusPkg.sv
frameTypesPkg.sv
cfgReadIf.sv
apbConfigPort.sv
configFsm.sv
frameLoader.sv
configTop.sv
tbClock.sv
tbConfigTop.sv

// ==== frameLoader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fabric_cfg.svh"

module frameLoader (
  input  wire logic                   CLK,
  input  wire logic                   resetn,
  input  wire logic [31:0]            wordData,
  input  wire frameTypesPkg::rowSelT  rowSelect,
  input  wire logic [`FRAME_BITS-1:0] frameAddr,
  input  wire logic                   longStrobe,
  cfgReadIf.loader                    rd
);

  import frameTypesPkg::*;

  localparam rowSelT maxRow = rowSelT'(`NUM_ROWS);

  logic [31:0] staging [`NUM_ROWS];                 // rows of the frame in flight
  logic [31:0] cfgMem  [`NUM_FRAMES][`NUM_ROWS];    // stands in for tile latches
  logic        rowValid;
  rowIdxT      slotIdx;
  frameIdxT    frameSel;
  logic        prevLongStrobe;
  logic        commit;
  frameCountT  frameCount;

  assign rowValid = (rowSelect != '0) && (rowSelect <= maxRow);
  assign slotIdx  = rowIdxT'(rowSelect - 1'b1);       // row N lands in slot N-1
  assign frameSel = frameIdxT'(frameAddr[frameIdxMsb:0]);
  assign commit   = longStrobe & ~prevLongStrobe;     // first cycle only

  always_ff @(posedge CLK) begin
    if (rowValid) begin
      staging[slotIdx] <= wordData;
    end
  end

  // config latches come up cleared, like the fabric after power on
  always_ff @(posedge CLK or negedge resetn) begin
    if (!resetn) begin
      prevLongStrobe <= 1'b0;
      frameCount     <= '0;
      for (int f = 0; f < `NUM_FRAMES; f++) begin
        for (int r = 0; r < `NUM_ROWS; r++) begin
          cfgMem[f][r] <= '0;
        end
      end
    end else begin
      prevLongStrobe <= longStrobe;
      if (commit) begin
        for (int r = 0; r < `NUM_ROWS; r++) begin
          cfgMem[frameSel][r] <= staging[r];   // whole frame at once
        end
        frameCount <= frameCount + 1'b1;
      end
    end
  end

  assign rd.readData   = cfgMem[rd.readFrame][rd.readRow];
  assign rd.frameCount = frameCount;

endmodule

`default_nettype wire

// ==== frameTypesPkg.sv ====
`default_nettype none

`include "fabric_cfg.svh"

package frameTypesPkg;

  typedef enum logic [1:0] {
    UNSYNCED,                     // waiting for sync word
    SYNCED,                       // waiting for header
    LOADING                       // shifting row words
  } cfgStateE;

  typedef logic [`ROW_SEL_WIDTH-1:0]     rowSelT;    // 0 and all ones mean no row
  typedef logic [$clog2(`NUM_FRAMES)-1:0] frameIdxT;
  typedef logic [$clog2(`NUM_ROWS)-1:0]   rowIdxT;
  typedef logic [7:0]                     frameCountT; // committed frames, wraps

  // frame index sits in the low header bits
  localparam int frameIdxMsb = 2;

endpackage

`default_nettype wire

// ==== tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter real halfPeriod = 4.0   // 8 ns period
) (
  output logic CLK
);

  initial begin
    CLK = 1'b0;
    forever begin
      #(halfPeriod) CLK = ~CLK;
    end
  end

endmodule

`default_nettype wire

// ==== tbConfigTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fabric_cfg.svh"

module tbConfigTop;

  import cfgBusPkg::*;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_WRERR, OP_RDERR, OP_WAIT} stepOpE;

  typedef struct packed {
    stepOpE      op;
    logic [7:0]  offset;
    logic [31:0] data;            // write data, idle cycles for OP_WAIT
    logic [31:0] expected;        // read value for OP_RD
  } stepT;

  logic        CLK;
  logic        resetn;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apbAddrT     paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  stepT        steps[$];
  logic [31:0] modelMem [`NUM_FRAMES][`NUM_ROWS];   // expected config memory
  int          modelCount;        // expected frameCount
  logic        modelSynced;
  integer      seed = 74419;
  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleCount = 0;
  int          cycleLimit = 1000000;

  tbClock iClock (.CLK(CLK));

  configTop i_dut (
    .CLK     (CLK),
    .resetn  (resetn),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  task automatic check(input string sigName, input logic [31:0] actual,
                       input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERR %s: got %h expected %h at %0t", sigName, actual, expected, $time);
    end
  endtask

  task automatic apbWrite(input apbAddrT addr, input logic [31:0] data, output logic err);
    @(posedge CLK);
    #1;
    psel    = 1'b1;               // setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge CLK);
    #1;
    penable = 1'b1;               // access phase
    @(negedge CLK);
    err = pslverr;
    check("pready", {31'b0, pready}, 32'h1);   // no wait states
    @(posedge CLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apbRead(input apbAddrT addr, output logic [31:0] data, output logic err);
    @(posedge CLK);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    @(negedge CLK);               // prdata settled mid access
    data = prdata;
    err  = pslverr;
    check("pready", {31'b0, pready}, 32'h1);
    @(posedge CLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic addStep(input stepOpE op, input logic [7:0] offset,
                         input logic [31:0] data, input logic [31:0] expected);
    stepT s;
    s.op       = op;
    s.offset   = offset;
    s.data     = data;
    s.expected = expected;
    steps.push_back(s);
  endtask

  // never hands out the sync pattern by accident
  function automatic logic [31:0] nextWord();
    logic [31:0] w;
    w = $random(seed);
    if (w == `SYNC_WORD) begin
      w = ~w;
    end
    return w;
  endfunction

  task automatic sendWord(input logic [31:0] word);
    addStep(OP_WR, DATA, word, '0);
  endtask

  task automatic sendJunk(input int count);
    for (int i = 0; i < count; i++) begin
      sendWord(nextWord());       // ignored while unsynced
    end
  endtask

  task automatic settle();
    addStep(OP_WAIT, '0, 32'd4, '0);   // let the frame commit land
  endtask

  task automatic expectStatus();
    logic [31:0] value;
    value       = '0;
    value[0]    = modelSynced;
    value[15:8] = modelCount[7:0];
    addStep(OP_RD, STATUS, '0, value);
  endtask

  task automatic sendSync();
    sendWord(`SYNC_WORD);
    modelSynced = 1'b1;
  endtask

  task automatic loadFrame(input int frame);
    logic [31:0] word;
    sendWord(32'(frame));         // header, desync bit clear
    for (int k = 0; k < `NUM_ROWS; k++) begin
      word = nextWord();
      sendWord(word);
      modelMem[frame][`NUM_ROWS-1-k] = word;   // first word to the top row
    end
    modelCount++;
  endtask

  task automatic readBackRow(input int frame, input int row);
    addStep(OP_WR, RDSEL, 32'((row << 8) | frame), '0);
    addStep(OP_RD, RDDATA, '0, modelMem[frame][row]);
  endtask

  task automatic readBackFrame(input int frame);
    for (int r = 0; r < `NUM_ROWS; r++) begin
      readBackRow(frame, r);
    end
  endtask

  task automatic buildTable();
    for (int f = 0; f < `NUM_FRAMES; f++) begin
      for (int r = 0; r < `NUM_ROWS; r++) begin
        modelMem[f][r] = '0;      // memory comes up cleared
      end
    end
    modelCount  = 0;
    modelSynced = 1'b0;
    // preamble before sync, shaped like a full frame 0
    expectStatus();
    sendWord(32'd0);
    sendJunk(`NUM_ROWS);
    expectStatus();
    readBackRow(0, 0);
    readBackRow(0, `NUM_ROWS-1);
    // one frame to index 3
    sendSync();
    expectStatus();
    loadFrame(3);
    settle();
    expectStatus();
    readBackFrame(3);
    // desync header, following words dropped
    sendWord(32'(1 << `DESYNC_BIT) | 32'd5);
    modelSynced = 1'b0;
    expectStatus();
    sendJunk(`NUM_ROWS);
    settle();
    expectStatus();
    readBackRow(5, 0);
    readBackRow(5, `NUM_ROWS-1);
    // back to back frames
    sendSync();
    loadFrame(1);
    loadFrame(6);
    loadFrame(0);
    settle();
    expectStatus();
    readBackFrame(1);
    readBackFrame(6);
    readBackFrame(0);
    readBackFrame(3);
    // comActive edge mid frame
    sendSync();
    sendWord(32'd2);
    sendJunk(7);
    addStep(OP_WR, CTRL, 32'h1, '0);
    modelSynced = 1'b0;
    expectStatus();
    sendJunk(`NUM_ROWS - 7);
    settle();
    expectStatus();
    readBackRow(2, 0);
    readBackRow(2, `NUM_ROWS-1);
    readBackFrame(3);
    readBackFrame(6);
    addStep(OP_RD, CTRL, '0, 32'h1);
    addStep(OP_WR, CTRL, 32'h0, '0);
    // bad accesses
    addStep(OP_WRERR, RDDATA, 32'hDEAD_BEEF, '0);
    addStep(OP_WRERR, STATUS, 32'h1, '0);
    addStep(OP_RDERR, 8'h14, '0, '0);
    addStep(OP_WRERR, 8'h20, 32'h1, '0);
    expectStatus();
  endtask

  task automatic runStep(input stepT s);
    logic [31:0] rdata;
    logic        err;
    case (s.op)
      OP_WR: begin
        apbWrite(s.offset, s.data, err);
        check("pslverr", {31'b0, err}, 32'h0);
      end
      OP_RD: begin
        apbRead(s.offset, rdata, err);
        check("pslverr", {31'b0, err}, 32'h0);
        check("prdata", rdata, s.expected);
      end
      OP_WRERR: begin
        apbWrite(s.offset, s.data, err);
        check("pslverr", {31'b0, err}, 32'h1);
      end
      OP_RDERR: begin
        apbRead(s.offset, rdata, err);
        check("pslverr", {31'b0, err}, 32'h1);
      end
      default: begin
        repeat (s.data) @(posedge CLK);
      end
    endcase
  endtask

  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: test did not finish within %0d cycles", cycleLimit);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    resetn  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    buildTable();
    cycleLimit = 40 * steps.size() + 100;
    repeat (10) @(posedge CLK);
    #1;
    resetn = 1'b1;
    foreach (steps[i]) begin
      runStep(steps[i]);
    end
    $display("steps %0d, checks %0d, errors %0d", steps.size(), checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
